// ==== board_pkg.sv ====
// memory map, i/o map and enums shared by the system board RTL and its testbench
`default_nettype none

package board_pkg;

   localparam int ADDR_W = 20;   // 1 MB address space
   localparam int DATA_W = 8;

   localparam int IO_DEV_COUNT = 6;
   localparam int ROM_CS_COUNT = 8;   // 8 KB per ROM socket
   localparam int RAM_BANKS = 4;   // 64 KB per bank

   // cycles from req sampled to ack
   localparam int MEM_WAIT = 2;
   localparam int IO_WAIT = 3;   // one extra wait state on i/o

   localparam logic [3:0] ROM_SEGMENT = 4'hF;   // a19..a16 for ROM
   localparam logic [1:0] RAM_TOP_BITS = 2'b00;   // a19..a18, lower 256 KB
   localparam int NMI_MASK_BIT = 7;

   typedef enum logic [1:0] {
      CMD_IOR,
      CMD_IOW,
      CMD_MEMR,
      CMD_MEMW
   } bus_cmd_e;

   // device index is a7..a5, same order as the LS138 outputs on the board
   typedef enum logic [2:0] {
      DEV_DMA  = 3'd0,
      DEV_PIC  = 3'd1,
      DEV_PIT  = 3'd2,
      DEV_PPI  = 3'd3,
      DEV_NMI  = 3'd5,   // port A0h
      DEV_PAGE = 3'd4    // port 80h
   } io_dev_e;

   typedef enum logic [1:0] {HOLD_IDLE, HOLD_GRANT, HOLD_AEN} hold_state_e;

   typedef enum logic [1:0] {CYC_IDLE, CYC_RUN, CYC_DONE} cycle_state_e;

endpackage

`default_nettype wire

// ==== bus_if.sv ====
// accepted bus cycle, driven by the sequencer and watched by the i/o and memory decoders
`timescale 1ns/1ps
`default_nettype none

interface bus_if;

   logic valid;   // cycle in progress
   logic start;   // first cycle of valid only
   board_pkg::bus_cmd_e cmd;
   logic [board_pkg::ADDR_W-1:0] addr;
   logic [board_pkg::DATA_W-1:0] wdata;

   modport ctrl (
      output valid, start, cmd, addr, wdata
   );

   modport decode (
      input valid, start, cmd, addr, wdata
   );

endinterface

`default_nettype wire

// ==== bus_cycle_ctrl.sv ====
// bus cycle sequencer, accepts a req/ack request and holds the cycle on bus_if with wait states
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_ctrl (
   input  wire                          clk,
   input  wire                          reset_n,
   input  wire                          req_i,
   input  wire board_pkg::bus_cmd_e     cmd_i,
   input  wire [board_pkg::ADDR_W-1:0]  addr_i,
   input  wire [board_pkg::DATA_W-1:0]  wdata_i,
   input  wire                          hold_busy_i,
   output logic                         ack_o,
   output logic                         cycle_idle_o,
   bus_if.ctrl                          bus
);

   board_pkg::cycle_state_e state_q;
   logic [1:0] wait_cnt;
   logic       io_cmd;
   logic       accept;

   assign io_cmd = (cmd_i == board_pkg::CMD_IOR) || (cmd_i == board_pkg::CMD_IOW);
   assign accept = (state_q == board_pkg::CYC_IDLE) && req_i && !hold_busy_i;
   assign cycle_idle_o = (state_q == board_pkg::CYC_IDLE) && !req_i;   // cpu wins a tie with hrq

   // payload latched once per cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         bus.cmd <= cmd_i;
         bus.addr <= addr_i;
         bus.wdata <= wdata_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state_q <= board_pkg::CYC_IDLE;
         wait_cnt <= '0;
         bus.valid <= 1'b0;
         bus.start <= 1'b0;
         ack_o <= 1'b0;
      end else begin
         bus.start <= accept;
         case (state_q)
            board_pkg::CYC_IDLE: begin
               if (accept) begin
                  bus.valid <= 1'b1;
                  wait_cnt <= io_cmd ? 2'(board_pkg::IO_WAIT - 1) : 2'(board_pkg::MEM_WAIT - 1);
                  state_q <= board_pkg::CYC_RUN;
               end
            end
            board_pkg::CYC_RUN: begin
               if (wait_cnt == 2'd1) begin
                  ack_o <= 1'b1;
                  state_q <= board_pkg::CYC_DONE;
               end else begin
                  wait_cnt <= wait_cnt - 2'd1;
               end
            end
            board_pkg::CYC_DONE: begin
               if (!req_i) begin   // master let go, end the cycle
                  ack_o <= 1'b0;
                  bus.valid <= 1'b0;
                  state_q <= board_pkg::CYC_IDLE;
               end
            end
            default: state_q <= board_pkg::CYC_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hold_arbiter.sv ====
// DMA hold arbiter, turns hrq into hold acknowledge and then address enable between cpu cycles
`timescale 1ns/1ps
`default_nettype none

module hold_arbiter (
   input  wire  clk,
   input  wire  reset_n,
   input  wire  hrq_i,
   input  wire  cycle_idle_i,
   output logic holda_o,
   output logic aen_o,
   output logic hold_busy_o
);

   board_pkg::hold_state_e state_q;
   board_pkg::hold_state_e state_d;

   always_comb begin
      state_d = state_q;
      case (state_q)
         board_pkg::HOLD_IDLE: begin
            // grant only when no cpu cycle is running or starting
            if (hrq_i && cycle_idle_i) begin
               state_d = board_pkg::HOLD_GRANT;
            end
         end
         board_pkg::HOLD_GRANT: begin
            state_d = board_pkg::HOLD_AEN;   // aen follows holda, like the LS175 stage
         end
         board_pkg::HOLD_AEN: begin
            if (!hrq_i) begin
               state_d = board_pkg::HOLD_IDLE;
            end
         end
         default: state_d = board_pkg::HOLD_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state_q <= board_pkg::HOLD_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign holda_o = (state_q == board_pkg::HOLD_GRANT) || (state_q == board_pkg::HOLD_AEN);
   assign aen_o = (state_q == board_pkg::HOLD_AEN);
   assign hold_busy_o = (state_q == board_pkg::HOLD_GRANT);   // blocks new cycles

endmodule

`default_nettype wire

// ==== io_space.sv ====
// i/o address decoder for the peripheral chip selects, with the NMI mask port and NMI output
`timescale 1ns/1ps
`default_nettype none

module io_space (
   input  wire                                  clk,
   input  wire                                  reset_n,
   input  wire                                  io_ch_ck_i,
   input  wire                                  aen_i,
   output logic [board_pkg::IO_DEV_COUNT-1:0]   io_cs_n_o,
   output logic                                 nmi_o,
   bus_if.decode                                bus
);

   board_pkg::io_dev_e dev;
   logic io_cmd;
   logic io_hit;
   logic write_only;
   logic dev_ok;
   logic [board_pkg::IO_DEV_COUNT-1:0] io_sel;
   logic nmi_mask_q;

   assign dev = board_pkg::io_dev_e'(bus.addr[7:5]);
   assign io_cmd = (bus.cmd == board_pkg::CMD_IOR) || (bus.cmd == board_pkg::CMD_IOW);

   // only the first 256 ports live on the board, and never while DMA owns the bus
   assign io_hit = bus.valid && io_cmd && (bus.addr[9:8] == 2'b00) && !aen_i;

   // nmi mask and page register cannot be read back
   assign write_only = (dev == board_pkg::DEV_NMI) || (dev == board_pkg::DEV_PAGE);
   assign dev_ok = io_hit && (!write_only || (bus.cmd == board_pkg::CMD_IOW));

   always_comb begin
      io_sel = '0;
      for (int i = 0; i < board_pkg::IO_DEV_COUNT; i++) begin
         io_sel[i] = dev_ok && (bus.addr[7:5] == 3'(i));
      end
   end

   assign io_cs_n_o = ~io_sel;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         nmi_mask_q <= 1'b0;
         nmi_o <= 1'b0;
      end else begin
         if (bus.start && io_sel[board_pkg::DEV_NMI]) begin
            nmi_mask_q <= bus.wdata[board_pkg::NMI_MASK_BIT];   // d7 enables nmi
         end
         nmi_o <= nmi_mask_q && io_ch_ck_i;
      end
   end

endmodule

`default_nettype wire

// ==== mem_space.sv ====
// memory address decoder for the ROM chip selects and the RAM bank RAS/CAS strobes
`timescale 1ns/1ps
`default_nettype none

module mem_space (
   input  wire                                  clk,
   input  wire                                  reset_n,
   output logic [board_pkg::ROM_CS_COUNT-1:0]   rom_cs_n_o,
   output logic [board_pkg::RAM_BANKS-1:0]      ras_n_o,
   output logic [board_pkg::RAM_BANKS-1:0]      cas_n_o,
   bus_if.decode                                bus
);

   logic mem_cmd;
   logic rom_hit;
   logic ram_hit;
   logic started_q;   // past the start cycle of this access
   logic [board_pkg::ROM_CS_COUNT-1:0] rom_sel;
   logic [board_pkg::RAM_BANKS-1:0] ras_sel;

   assign mem_cmd = (bus.cmd == board_pkg::CMD_MEMR) || (bus.cmd == board_pkg::CMD_MEMW);

   // ROM is read only, RAM takes reads and writes
   assign rom_hit = bus.valid && (bus.cmd == board_pkg::CMD_MEMR)
                    && (bus.addr[19:16] == board_pkg::ROM_SEGMENT);
   assign ram_hit = bus.valid && mem_cmd && (bus.addr[19:18] == board_pkg::RAM_TOP_BITS);

   always_comb begin
      rom_sel = '0;
      ras_sel = '0;
      for (int i = 0; i < board_pkg::ROM_CS_COUNT; i++) begin
         rom_sel[i] = rom_hit && (bus.addr[15:13] == 3'(i));   // 8 KB sockets
      end
      for (int b = 0; b < board_pkg::RAM_BANKS; b++) begin
         ras_sel[b] = ram_hit && (bus.addr[17:16] == 2'(b));
      end
   end

   // cas trails ras by one clock instead of the delay line
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         started_q <= 1'b0;
      end else if (!bus.valid) begin
         started_q <= 1'b0;
      end else if (bus.start) begin
         started_q <= 1'b1;
      end
   end

   assign rom_cs_n_o = ~rom_sel;
   assign ras_n_o = ~ras_sel;
   assign cas_n_o = ~(ras_sel & {board_pkg::RAM_BANKS{started_q}});

endmodule

`default_nettype wire

// ==== system_board.sv ====
// system board control top level, connects sequencer, hold arbiter and both decoders to plain ports
`timescale 1ns/1ps
`default_nettype none

module system_board (
   input  wire                                  clk,
   input  wire                                  reset_n,
   input  wire                                  req_i,
   input  wire board_pkg::bus_cmd_e             cmd_i,
   input  wire [board_pkg::ADDR_W-1:0]          addr_i,
   input  wire [board_pkg::DATA_W-1:0]          wdata_i,
   input  wire                                  hrq_i,
   input  wire                                  io_ch_ck_i,
   output wire                                  ack_o,
   output wire                                  holda_o,
   output wire                                  aen_o,
   output wire                                  nmi_o,
   output wire [board_pkg::IO_DEV_COUNT-1:0]    io_cs_n_o,
   output wire [board_pkg::ROM_CS_COUNT-1:0]    rom_cs_n_o,
   output wire [board_pkg::RAM_BANKS-1:0]       ras_n_o,
   output wire [board_pkg::RAM_BANKS-1:0]       cas_n_o
);

   wire hold_busy;    // arbiter in grant, no new cycles
   wire cycle_idle;   // sequencer free for a hold grant

   bus_if bus ();

   bus_cycle_ctrl u_bus_cycle_ctrl (
      .clk          (clk),
      .reset_n      (reset_n),
      .req_i        (req_i),
      .cmd_i        (cmd_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .hold_busy_i  (hold_busy),
      .ack_o        (ack_o),
      .cycle_idle_o (cycle_idle),
      .bus          (bus.ctrl)
   );

   hold_arbiter u_hold_arbiter (
      .clk          (clk),
      .reset_n      (reset_n),
      .hrq_i        (hrq_i),
      .cycle_idle_i (cycle_idle),
      .holda_o      (holda_o),
      .aen_o        (aen_o),
      .hold_busy_o  (hold_busy)
   );

   io_space u_io_space (
      .clk          (clk),
      .reset_n      (reset_n),
      .io_ch_ck_i   (io_ch_ck_i),
      .aen_i        (aen_o),   // board i/o stays quiet under DMA
      .io_cs_n_o    (io_cs_n_o),
      .nmi_o        (nmi_o),
      .bus          (bus.decode)
   );

   mem_space u_mem_space (
      .clk          (clk),
      .reset_n      (reset_n),
      .rom_cs_n_o   (rom_cs_n_o),
      .ras_n_o      (ras_n_o),
      .cas_n_o      (cas_n_o),
      .bus          (bus.decode)
   );

endmodule

`default_nettype wire

// ==== system_board_assert.sv ====
// concurrent checks on the bus handshake, hold outputs and RAS strobes, bound into the system board
`timescale 1ns/1ps
`default_nettype none

module system_board_assert (
   input wire                           clk,
   input wire                           reset_n,
   input wire                           req_i,
   input wire                           ack_i,
   input wire                           holda_i,
   input wire                           aen_i,
   input wire [board_pkg::RAM_BANKS-1:0] ras_n_i
);

   // ack only rises on a clock where req was high
   ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(ack_i) |-> $past(req_i))
      else $error("ack rose while req was low");

   aen_needs_holda: assert property (@(posedge clk) disable iff (!reset_n)
      aen_i |-> holda_i)
      else $error("aen high without holda");

   // one bank strobed at a time
   one_ras_bank: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(~ras_n_i))
      else $error("more than one ras strobe low");

endmodule

bind system_board system_board_assert u_system_board_assert (
   .clk     (clk),
   .reset_n (reset_n),
   .req_i   (req_i),
   .ack_i   (ack_o),
   .holda_i (holda_o),
   .aen_i   (aen_o),
   .ras_n_i (ras_n_o)
);

`default_nettype wire

// ==== tb_clock.sv ====
// testbench clock and reset source, 20 ns clock with reset held low for the first 5 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk_o,
   output logic reset_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;   // 20 ns period
   end

   initial begin
      reset_n_o = 1'b0;
      repeat (5) @(posedge clk_o);
      #1;
      reset_n_o = 1'b1;   // released just after the 5th edge
   end

endmodule

`default_nettype wire

// ==== tb_system_board.sv ====
// testbench that runs random bus and hold traffic on the system board against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_system_board;

   localparam int WAIT_LIMIT = 20;   // cycles before any wait gives up

   wire clk;
   wire reset_n;
   logic req;
   board_pkg::bus_cmd_e cmd;
   logic [board_pkg::ADDR_W-1:0] addr;
   logic [board_pkg::DATA_W-1:0] wdata;
   logic hrq;
   logic io_ch_ck;
   wire ack;
   wire holda;
   wire aen;
   wire nmi;
   wire [board_pkg::IO_DEV_COUNT-1:0] io_cs_n;
   wire [board_pkg::ROM_CS_COUNT-1:0] rom_cs_n;
   wire [board_pkg::RAM_BANKS-1:0] ras_n;
   wire [board_pkg::RAM_BANKS-1:0] cas_n;

   logic [31:0] rng = 32'h7d3f;
   int errors = 0;
   logic timed_out = 1'b0;
   string timeout_what = "";
   logic aen_model = 1'b0;        // expected address enable during a cycle
   logic nmi_mask_model = 1'b0;

   tb_clock clk_gen (
      .clk_o     (clk),
      .reset_n_o (reset_n)
   );

   system_board dut (
      .clk        (clk),
      .reset_n    (reset_n),
      .req_i      (req),
      .cmd_i      (cmd),
      .addr_i     (addr),
      .wdata_i    (wdata),
      .hrq_i      (hrq),
      .io_ch_ck_i (io_ch_ck),
      .ack_o      (ack),
      .holda_o    (holda),
      .aen_o      (aen),
      .nmi_o      (nmi),
      .io_cs_n_o  (io_cs_n),
      .rom_cs_n_o (rom_cs_n),
      .ras_n_o    (ras_n),
      .cas_n_o    (cas_n)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] draw_random();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // one active-low select from a7..a5 for on-board ports when DMA does not own the bus
   function automatic logic [board_pkg::IO_DEV_COUNT-1:0] io_select_model(
      input board_pkg::bus_cmd_e c, input logic [board_pkg::ADDR_W-1:0] a, input logic dma);
      logic [board_pkg::IO_DEV_COUNT-1:0] cs_n;
      int dev;
      logic is_io;
      logic write_only;
      cs_n = '1;
      dev = int'(a[7:5]);
      is_io = (c == board_pkg::CMD_IOR) || (c == board_pkg::CMD_IOW);
      write_only = (dev == int'(board_pkg::DEV_NMI)) || (dev == int'(board_pkg::DEV_PAGE));
      if (is_io && a[9:8] == 2'b00 && !dma && dev < board_pkg::IO_DEV_COUNT) begin
         if (c == board_pkg::CMD_IOW || !write_only) begin
            cs_n[dev] = 1'b0;
         end
      end
      return cs_n;
   endfunction

   function automatic logic [board_pkg::ROM_CS_COUNT-1:0] rom_select_model(
      input board_pkg::bus_cmd_e c, input logic [board_pkg::ADDR_W-1:0] a);
      logic [board_pkg::ROM_CS_COUNT-1:0] cs_n;
      cs_n = '1;
      if (c == board_pkg::CMD_MEMR && a[19:16] == board_pkg::ROM_SEGMENT) begin
         cs_n[a[15:13]] = 1'b0;
      end
      return cs_n;
   endfunction

   // bank strobe for reads and writes in the low 256 KB
   function automatic logic [board_pkg::RAM_BANKS-1:0] ram_strobe_model(
      input board_pkg::bus_cmd_e c, input logic [board_pkg::ADDR_W-1:0] a);
      logic [board_pkg::RAM_BANKS-1:0] strobe_n;
      strobe_n = '1;
      if ((c == board_pkg::CMD_MEMR || c == board_pkg::CMD_MEMW)
          && a[19:18] == board_pkg::RAM_TOP_BITS) begin
         strobe_n[a[17:16]] = 1'b0;
      end
      return strobe_n;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      errors++;
      $display("FAILED %s expected %0h actual %0h at %0t", name, expected, actual, $time);
   endtask

   task automatic flag_timeout(input string what);
      errors++;
      timeout_what = what;
      timed_out = 1'b1;
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;   // drive and sample just after the edge
   endtask

   // full four-phase cycle that checks latency and decode while ack is high
   task automatic run_cycle(input string name, input board_pkg::bus_cmd_e c,
                            input logic [board_pkg::ADDR_W-1:0] a,
                            input logic [board_pkg::DATA_W-1:0] d, input int latency);
      int cycles;
      int start_at;
      logic [board_pkg::IO_DEV_COUNT-1:0] exp_io;
      logic [board_pkg::ROM_CS_COUNT-1:0] exp_rom;
      logic [board_pkg::RAM_BANKS-1:0] exp_ram;
      exp_io = io_select_model(c, a, aen_model);
      exp_rom = rom_select_model(c, a);
      exp_ram = ram_strobe_model(c, a);
      // valid comes up one cycle after acceptance and ack follows after the wait count
      if (c == board_pkg::CMD_MEMR || c == board_pkg::CMD_MEMW) begin
         start_at = latency - board_pkg::MEM_WAIT + 1;
      end else begin
         start_at = latency - board_pkg::IO_WAIT + 1;
      end
      req = 1'b1;
      cmd = c;
      addr = a;
      wdata = d;
      cycles = 0;
      while (!ack && cycles < WAIT_LIMIT) begin
         next_cycle();
         cycles++;
         if (cycles == start_at) begin
            if (ras_n != exp_ram) begin
               report_mismatch({name, " ras_n start"}, exp_ram, ras_n);
            end
            if (cas_n != '1) begin   // only ras is down in the start cycle
               report_mismatch({name, " cas_n start"}, '1, cas_n);
            end
         end
      end
      if (!ack) begin
         flag_timeout({name, " ack"});
      end
      if (cycles != latency) begin
         report_mismatch({name, " latency"}, latency, cycles);
      end
      if (aen != aen_model) begin
         report_mismatch({name, " aen"}, aen_model, aen);
      end
      if (io_cs_n != exp_io) begin
         report_mismatch({name, " io_cs_n"}, exp_io, io_cs_n);
      end
      if (rom_cs_n != exp_rom) begin
         report_mismatch({name, " rom_cs_n"}, exp_rom, rom_cs_n);
      end
      if (ras_n != exp_ram) begin
         report_mismatch({name, " ras_n"}, exp_ram, ras_n);
      end
      if (cas_n != exp_ram) begin   // cas is down by the time ack rises
         report_mismatch({name, " cas_n"}, exp_ram, cas_n);
      end
      if (c == board_pkg::CMD_IOW && !exp_io[board_pkg::DEV_NMI]) begin
         nmi_mask_model = d[board_pkg::NMI_MASK_BIT];
      end
      req = 1'b0;
      next_cycle();
      if (ack) begin
         report_mismatch({name, " ack release"}, 0, ack);
      end
      if (io_cs_n != '1 || rom_cs_n != '1) begin
         report_mismatch({name, " selects idle"}, '1, {rom_cs_n, io_cs_n});
      end
      if (ras_n != '1 || cas_n != '1) begin
         report_mismatch({name, " strobes idle"}, '1, {ras_n, cas_n});
      end
   endtask

   initial begin
      wait (timed_out);
      $display("timeout while waiting for %s", timeout_what);
      $display("run stopped, %0d errors", errors);
      $display("test failed");
      $finish;
   end

   initial begin
      int n;
      logic [31:0] r;
      logic [board_pkg::ADDR_W-1:0] a;
      board_pkg::bus_cmd_e c;
      req = 1'b0;
      cmd = board_pkg::CMD_IOR;
      addr = '0;
      wdata = '0;
      hrq = 1'b0;
      io_ch_ck = 1'b0;

      n = 0;
      while (reset_n !== 1'b1 && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (reset_n !== 1'b1) begin
         flag_timeout("reset release");
      end
      #1;
      if ({ack, holda, aen, nmi} != 4'b0000) begin
         report_mismatch("reset outputs", 0, {ack, holda, aen, nmi});
      end
      if (io_cs_n != '1 || rom_cs_n != '1 || ras_n != '1 || cas_n != '1) begin
         report_mismatch("reset selects", '1, {io_cs_n, rom_cs_n, ras_n, cas_n});
      end

      // random i/o mostly to on-board ports
      for (int i = 0; i < 40; i++) begin
         r = draw_random();
         a = r[19:0];
         if (r[31:30] != 2'b00) begin
            a[9:8] = 2'b00;
         end
         c = r[29] ? board_pkg::CMD_IOW : board_pkg::CMD_IOR;
         run_cycle("io", c, a, r[27:20], board_pkg::IO_WAIT);
      end

      // random memory biased toward ROM and RAM
      for (int i = 0; i < 40; i++) begin
         r = draw_random();
         a = r[19:0];
         case (r[31:30])
            2'd0: a[19:16] = board_pkg::ROM_SEGMENT;
            2'd1, 2'd2: a[19:18] = board_pkg::RAM_TOP_BITS;
            default: ;
         endcase
         c = r[29] ? board_pkg::CMD_MEMW : board_pkg::CMD_MEMR;
         run_cycle("mem", c, a, r[27:20], board_pkg::MEM_WAIT);
      end

      // nmi mask port at A0h
      for (int i = 0; i < 12; i++) begin
         r = draw_random();
         io_ch_ck = r[0];
         next_cycle();
         a = {r[19:10], 2'b00, 3'(board_pkg::DEV_NMI), r[4:0]};
         c = (r[2:1] == 2'b00) ? board_pkg::CMD_IOR : board_pkg::CMD_IOW;
         run_cycle("nmi port", c, a, r[27:20], board_pkg::IO_WAIT);
         if (nmi != (nmi_mask_model & io_ch_ck)) begin
            report_mismatch("nmi after write", nmi_mask_model & io_ch_ck, nmi);
         end
         for (int k = 0; k < 3; k++) begin
            r = draw_random();
            io_ch_ck = r[8];
            next_cycle();
            if (nmi != (nmi_mask_model & io_ch_ck)) begin
               report_mismatch("nmi io_ch_ck", nmi_mask_model & io_ch_ck, nmi);
            end
         end
      end
      io_ch_ck = 1'b0;

      // hold from idle gives holda and then aen
      hrq = 1'b1;
      n = 0;
      while (!holda && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (!holda) begin
         flag_timeout("holda");
      end
      if (n != 1) begin
         report_mismatch("hold holda latency", 1, n);
      end
      if (aen) begin
         report_mismatch("hold aen early", 0, aen);
      end
      next_cycle();
      aen_model = 1'b1;
      if ({holda, aen} != 2'b11) begin
         report_mismatch("hold aen", 2'b11, {holda, aen});
      end
      for (int i = 0; i < 8; i++) begin
         r = draw_random();
         a = r[19:0];
         if (i % 2 == 0) begin
            a[9:8] = 2'b00;
            c = r[29] ? board_pkg::CMD_IOW : board_pkg::CMD_IOR;
            run_cycle("io under aen", c, a, r[27:20], board_pkg::IO_WAIT);
         end else begin
            if (r[31]) begin
               a[19:18] = board_pkg::RAM_TOP_BITS;
            end else begin
               a[19:16] = board_pkg::ROM_SEGMENT;
            end
            c = r[29] ? board_pkg::CMD_MEMW : board_pkg::CMD_MEMR;
            run_cycle("mem under aen", c, a, r[27:20], board_pkg::MEM_WAIT);
         end
      end
      hrq = 1'b0;
      next_cycle();
      aen_model = 1'b0;
      if ({holda, aen} != 2'b00) begin
         report_mismatch("hold release", 2'b00, {holda, aen});
      end

      // cpu request while the arbiter sits in grant
      hrq = 1'b1;
      next_cycle();
      if ({holda, aen} != 2'b10) begin
         report_mismatch("hold grant", 2'b10, {holda, aen});
      end
      aen_model = 1'b1;
      r = draw_random();
      a = r[19:0];
      a[9:8] = 2'b00;
      run_cycle("req in grant", board_pkg::CMD_IOR, a, 8'h00, board_pkg::IO_WAIT + 1);
      hrq = 1'b0;
      next_cycle();
      aen_model = 1'b0;
      if ({holda, aen} != 2'b00) begin
         report_mismatch("grant release", 2'b00, {holda, aen});
      end

      $display("checks done, %0d errors", errors);
      if (errors == 0 && !timed_out) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
board_pkg.sv
bus_if.sv
bus_cycle_ctrl.sv
hold_arbiter.sv
io_space.sv
mem_space.sv
system_board.sv
system_board_assert.sv
tb_clock.sv
tb_system_board.sv
